// File: logic/bus_arbiter.sv
`timescale 1ns/1ps

module bus_arbiter (
   input  logic               clk,
   input  logic               resetn,

   input  logic               ireq_valid_i,
   input  bus_pkg::addr_t     ireq_addr_i,
   output logic               ireq_ready_o,
   output logic               irsp_valid_o,
   output bus_pkg::bus_rsp_t  irsp_o,

   input  logic               dreq_valid_i,
   input  bus_pkg::bus_req_t  dreq_i,
   output logic               dreq_ready_o,
   output logic               drsp_valid_o,
   output bus_pkg::bus_rsp_t  drsp_o,

   output logic               req_valid_o,
   output bus_pkg::bus_req_t  req_o,
   input  logic               req_ready_i,
   input  logic               rsp_valid_i,
   input  bus_pkg::bus_rsp_t  rsp_i
);

   import bus_pkg::*;

   arb_state_e state_q;
   bus_req_t   ireq;
   logic       idle;

   // Fetch port never writes
   assign ireq = '{addr: ireq_addr_i, wdata: '0, write: 1'b0};

   assign idle = (state_q == ARB_IDLE);

   // Data port wins when both are valid
   assign req_valid_o = idle && (dreq_valid_i || ireq_valid_i);
   assign req_o       = dreq_valid_i ? dreq_i : ireq;

   assign dreq_ready_o = idle && req_ready_i && dreq_valid_i;
   assign ireq_ready_o = idle && req_ready_i && ireq_valid_i && !dreq_valid_i;

   always_ff @(posedge clk) begin
      if (!resetn) begin
         state_q <= ARB_IDLE;
      end else begin
         case (state_q)
            ARB_IDLE: begin
               if (dreq_ready_o) begin
                  state_q <= ARB_DATA;
               end else if (ireq_ready_o) begin
                  state_q <= ARB_INSTR;
               end
            end
            default: begin
               // Grant held until the completion comes back
               if (rsp_valid_i) begin
                  state_q <= ARB_IDLE;
               end
            end
         endcase
      end
   end

   // Completion steered to the owner of the grant
   assign drsp_valid_o = (state_q == ARB_DATA) && rsp_valid_i;
   assign irsp_valid_o = (state_q == ARB_INSTR) && rsp_valid_i;
   assign drsp_o       = rsp_i;
   assign irsp_o       = rsp_i;

   // Router only answers a transaction this arbiter granted
   assert property (@(posedge clk) disable iff (!resetn)
      rsp_valid_i |-> state_q != ARB_IDLE);

endmodule

// File: logic/bus_pkg.sv
`include "bus_settings.svh"

package bus_pkg;

   typedef logic [`BUS_ADDR_BITS-1:0] addr_t;
   typedef logic [`BUS_DATA_BITS-1:0] data_t;
   typedef logic [`BUS_STRB_BITS-1:0] strb_t;

   typedef struct packed {
      addr_t addr;
      data_t wdata;
      logic  write;
   } bus_req_t;

   // Write completions carry zero data
   typedef struct packed {
      data_t rdata;
      logic  err;
   } bus_rsp_t;

   typedef enum logic [1:0] {REGION_RAM, REGION_TIMER, REGION_PWM, REGION_NONE} region_e;

   typedef enum logic [1:0] {ROUTE_IDLE, ROUTE_MEM, ROUTE_PWM, ROUTE_NONE} route_state_e;

   typedef enum logic [1:0] {ARB_IDLE, ARB_INSTR, ARB_DATA} arb_state_e;

endpackage

// File: logic/bus_router.sv
`timescale 1ns/1ps

`include "bus_settings.svh"

module bus_router (
   input  logic               clk,
   input  logic               resetn,

   input  logic               req_valid_i,
   input  bus_pkg::bus_req_t  req_i,
   output logic               req_ready_o,
   output logic               rsp_valid_o,
   output bus_pkg::bus_rsp_t  rsp_o,

   output logic               iomem_valid_o,
   input  logic               iomem_ready_i,
   output bus_pkg::strb_t     iomem_wstrb_o,
   output bus_pkg::addr_t     iomem_addr_o,
   output bus_pkg::data_t     iomem_wdata_o,
   input  bus_pkg::data_t     iomem_rdata_i,

   output logic               pwm_sel_o,
   output bus_pkg::bus_req_t  pwm_req_o,
   input  bus_pkg::data_t     pwm_rdata_i
);

   import bus_pkg::*;

   route_state_e state_q;
   region_e      region;
   bus_req_t     req_q;
   data_t        mem_rdata_q;
   logic         mem_done_q;
   logic         accept;

   always_comb begin
      region = REGION_NONE;
      if ((req_i.addr & ~`RAM_MASK_ADDR) == `RAM_BASE_ADDR) begin
         region = REGION_RAM;
      end else if ((req_i.addr & ~`TIMER_MASK_ADDR) == `TIMER_BASE_ADDR) begin
         region = REGION_TIMER;
      end else if ((req_i.addr & ~`PWM_MASK_ADDR) == `PWM_BASE_ADDR) begin
         region = REGION_PWM;
      end
   end

   assign req_ready_o = (state_q == ROUTE_IDLE) && !mem_done_q;
   assign accept      = req_valid_i && req_ready_o;

   always_ff @(posedge clk) begin
      if (!resetn) begin
         state_q    <= ROUTE_IDLE;
         mem_done_q <= 1'b0;
      end else begin
         mem_done_q <= 1'b0;
         case (state_q)
            ROUTE_IDLE: begin
               if (accept) begin
                  case (region)
                     REGION_RAM, REGION_TIMER: state_q <= ROUTE_MEM;
                     REGION_PWM:               state_q <= ROUTE_PWM;
                     default:                  state_q <= ROUTE_NONE;
                  endcase
               end
            end
            ROUTE_MEM: begin
               if (iomem_ready_i) begin
                  state_q    <= ROUTE_IDLE;
                  mem_done_q <= 1'b1;
               end
            end
            default: state_q <= ROUTE_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         req_q <= req_i;
      end
      // Read data sampled in the ready cycle
      if (state_q == ROUTE_MEM && iomem_ready_i) begin
         mem_rdata_q <= req_q.write ? '0 : iomem_rdata_i;
      end
   end

   assign iomem_valid_o = (state_q == ROUTE_MEM);
   assign iomem_addr_o  = req_q.addr;
   assign iomem_wdata_o = req_q.wdata;
   assign iomem_wstrb_o = req_q.write ? '1 : '0;

   assign pwm_sel_o = (state_q == ROUTE_PWM);
   assign pwm_req_o = req_q;

   assign rsp_valid_o = mem_done_q || (state_q == ROUTE_PWM) || (state_q == ROUTE_NONE);

   always_comb begin
      case (state_q)
         ROUTE_PWM: rsp_o = '{rdata: req_q.write ? '0 : pwm_rdata_i, err: 1'b0};
         // Unmapped address
         ROUTE_NONE: rsp_o = '{rdata: '0, err: 1'b1};
         default:    rsp_o = '{rdata: mem_rdata_q, err: 1'b0};
      endcase
   end

   assert property (@(posedge clk) disable iff (!resetn)
      iomem_valid_o && !iomem_ready_i |=> $stable(iomem_addr_o));

endmodule

// File: logic/bus_settings.svh
`ifndef BUS_SETTINGS_SVH
`define BUS_SETTINGS_SVH

// Bus widths
`define BUS_ADDR_BITS 32
`define BUS_DATA_BITS 32
`define BUS_STRB_BITS 4

// Address map with masks over the offset bits of each region
`define RAM_BASE_ADDR   32'h0000_0000
`define RAM_MASK_ADDR   32'h0000_FFFF
`define TIMER_BASE_ADDR 32'h2000_0000
`define TIMER_MASK_ADDR 32'h0000_00FF
`define PWM_BASE_ADDR   32'h2002_0000
`define PWM_MASK_ADDR   32'h0000_000F

// PWM register offsets
`define PWM_PERIOD_OFF 32'h0000_0000
`define PWM_DUTY0_OFF  32'h0000_0004
`define PWM_DUTY1_OFF  32'h0000_0008
`define PWM_COUNT_OFF  32'h0000_000C

`define PWM_COUNT_BITS 16

`endif

// File: logic/pwm_controller.sv
`timescale 1ns/1ps

`include "bus_settings.svh"

module pwm_controller (
   input  logic               clk,
   input  logic               resetn,

   input  logic               sel_i,
   input  bus_pkg::bus_req_t  req_i,
   output bus_pkg::data_t     rdata_o,

   output logic               pwm0_o,
   output logic               pwm1_o
);

   import bus_pkg::*;
   import pwm_pkg::*;

   pwm_reg_e   reg_sel;
   pwm_count_t period_q;
   pwm_count_t duty0_q;
   pwm_count_t duty1_q;
   pwm_count_t count_q;
   pwm_count_t wr_val;
   logic       wr_en;

   always_comb begin
      case (req_i.addr & `PWM_MASK_ADDR)
         `PWM_PERIOD_OFF: reg_sel = PWM_REG_PERIOD;
         `PWM_DUTY0_OFF:  reg_sel = PWM_REG_DUTY0;
         `PWM_DUTY1_OFF:  reg_sel = PWM_REG_DUTY1;
         `PWM_COUNT_OFF:  reg_sel = PWM_REG_COUNT;
         default:         reg_sel = PWM_REG_NONE;
      endcase
   end

   assign wr_en  = sel_i && req_i.write;
   assign wr_val = req_i.wdata[`PWM_COUNT_BITS-1:0];

   // COUNT is read only
   always_ff @(posedge clk) begin
      if (!resetn) begin
         period_q <= '0;
         duty0_q  <= '0;
         duty1_q  <= '0;
      end else if (wr_en) begin
         case (reg_sel)
            PWM_REG_PERIOD: period_q <= wr_val;
            PWM_REG_DUTY0:  duty0_q  <= wr_val;
            PWM_REG_DUTY1:  duty1_q  <= wr_val;
            default: ;
         endcase
      end
   end

   // Restart on a period write, wrap at period minus one
   always_ff @(posedge clk) begin
      if (!resetn) begin
         count_q <= '0;
      end else if ((wr_en && reg_sel == PWM_REG_PERIOD) || period_q == '0) begin
         count_q <= '0;
      end else if (count_q >= period_q - 1'b1) begin
         count_q <= '0;
      end else begin
         count_q <= count_q + 1'b1;
      end
   end

   always_comb begin
      case (reg_sel)
         PWM_REG_PERIOD: rdata_o = data_t'(period_q);
         PWM_REG_DUTY0:  rdata_o = data_t'(duty0_q);
         PWM_REG_DUTY1:  rdata_o = data_t'(duty1_q);
         PWM_REG_COUNT:  rdata_o = data_t'(count_q);
         default:        rdata_o = '0;
      endcase
   end

   assign pwm0_o = (period_q != '0) && (count_q < duty0_q);
   assign pwm1_o = (period_q != '0) && (count_q < duty1_q);

   assert property (@(posedge clk) disable iff (!resetn)
      period_q != '0 |-> count_q < period_q);

endmodule

// File: logic/pwm_pkg.sv
`include "bus_settings.svh"

package pwm_pkg;

   typedef logic [`PWM_COUNT_BITS-1:0] pwm_count_t;

   // Register picked by the address offset
   typedef enum logic [2:0] {
      PWM_REG_PERIOD,
      PWM_REG_DUTY0,
      PWM_REG_DUTY1,
      PWM_REG_COUNT,
      PWM_REG_NONE
   } pwm_reg_e;

endpackage

// File: logic/system_bus.sv
`timescale 1ns/1ps

module system_bus (
   input  logic               clk,
   input  logic               resetn,

   input  logic               ireq_valid_i,
   input  bus_pkg::addr_t     ireq_addr_i,
   output logic               ireq_ready_o,
   output logic               irsp_valid_o,
   output bus_pkg::bus_rsp_t  irsp_o,

   input  logic               dreq_valid_i,
   input  bus_pkg::bus_req_t  dreq_i,
   output logic               dreq_ready_o,
   output logic               drsp_valid_o,
   output bus_pkg::bus_rsp_t  drsp_o,

   output logic               iomem_valid_o,
   input  logic               iomem_ready_i,
   output bus_pkg::strb_t     iomem_wstrb_o,
   output bus_pkg::addr_t     iomem_addr_o,
   output bus_pkg::data_t     iomem_wdata_o,
   input  bus_pkg::data_t     iomem_rdata_i,

   output logic               pwm0_o,
   output logic               pwm1_o
);

   import bus_pkg::*;

   // Shared bus between arbiter and router
   logic     req_valid;
   logic     req_ready;
   bus_req_t req;
   logic     rsp_valid;
   bus_rsp_t rsp;

   logic     pwm_sel;
   bus_req_t pwm_req;
   data_t    pwm_rdata;

   bus_arbiter i_bus_arbiter (
      .clk          (clk),
      .resetn       (resetn),
      .ireq_valid_i (ireq_valid_i),
      .ireq_addr_i  (ireq_addr_i),
      .ireq_ready_o (ireq_ready_o),
      .irsp_valid_o (irsp_valid_o),
      .irsp_o       (irsp_o),
      .dreq_valid_i (dreq_valid_i),
      .dreq_i       (dreq_i),
      .dreq_ready_o (dreq_ready_o),
      .drsp_valid_o (drsp_valid_o),
      .drsp_o       (drsp_o),
      .req_valid_o  (req_valid),
      .req_o        (req),
      .req_ready_i  (req_ready),
      .rsp_valid_i  (rsp_valid),
      .rsp_i        (rsp)
   );

   bus_router i_bus_router (
      .clk           (clk),
      .resetn        (resetn),
      .req_valid_i   (req_valid),
      .req_i         (req),
      .req_ready_o   (req_ready),
      .rsp_valid_o   (rsp_valid),
      .rsp_o         (rsp),
      .iomem_valid_o (iomem_valid_o),
      .iomem_ready_i (iomem_ready_i),
      .iomem_wstrb_o (iomem_wstrb_o),
      .iomem_addr_o  (iomem_addr_o),
      .iomem_wdata_o (iomem_wdata_o),
      .iomem_rdata_i (iomem_rdata_i),
      .pwm_sel_o     (pwm_sel),
      .pwm_req_o     (pwm_req),
      .pwm_rdata_i   (pwm_rdata)
   );

   pwm_controller i_pwm_controller (
      .clk     (clk),
      .resetn  (resetn),
      .sel_i   (pwm_sel),
      .req_i   (pwm_req),
      .rdata_o (pwm_rdata),
      .pwm0_o  (pwm0_o),
      .pwm1_o  (pwm1_o)
   );

endmodule

// File: system_bus.f
+incdir+logic
logic/bus_pkg.sv
logic/pwm_pkg.sv
logic/bus_arbiter.sv
logic/bus_router.sv
logic/pwm_controller.sv
logic/system_bus.sv
testbench/system_bus_tb.sv

// File: testbench/system_bus_cases.txt
# op port addr data expect err, all hex, port d or i
# pwm rows use port p0 or p1, data is the window in cycles, expect the high count
read  d  20020000 00000000 00000000 0
read  d  20020004 00000000 00000000 0
read  d  20020008 00000000 00000000 0
read  d  2002000c 00000000 00000000 0
write d  00000100 cafe0001 00000000 0
write d  20000010 0badf00d 00000000 0
read  d  00000100 00000000 cafe0001 0
read  d  20000010 00000000 0badf00d 0
read  i  00000100 00000000 cafe0001 0
dual  d  00000100 00000200 cafe0001 0
write d  20020000 0000000a 00000000 0
write d  20020004 00000003 00000000 0
write d  20020008 0000000e 00000000 0
write d  2002000c 00001234 00000000 0
read  d  20020000 00000000 0000000a 0
read  d  20020004 00000000 00000003 0
read  d  20020008 00000000 0000000e 0
pwm   p0 00000000 0000000a 00000003 0
pwm   p1 00000000 0000000a 0000000a 0
read  d  40000000 00000000 00000000 1
write d  40000000 12345678 00000000 1
read  d  00000100 00000000 cafe0001 0
read  d  20020000 00000000 0000000a 0
write d  20020000 00000000 00000000 0
pwm   p0 00000000 0000000a 00000000 0
pwm   p1 00000000 0000000a 00000000 0

// File: testbench/system_bus_tb.sv
`timescale 1ns/1ps

`include "bus_settings.svh"

module system_bus_tb;

   import bus_pkg::*;
   import pwm_pkg::*;

   logic     clk;
   logic     resetn;
   logic     ireq_valid_i;
   addr_t    ireq_addr_i;
   logic     ireq_ready_o;
   logic     irsp_valid_o;
   bus_rsp_t irsp_o;
   logic     dreq_valid_i;
   bus_req_t dreq_i;
   logic     dreq_ready_o;
   logic     drsp_valid_o;
   bus_rsp_t drsp_o;
   logic     iomem_valid_o;
   logic     iomem_ready_i;
   strb_t    iomem_wstrb_o;
   addr_t    iomem_addr_o;
   data_t    iomem_wdata_o;
   data_t    iomem_rdata_i;
   logic     pwm0_o;
   logic     pwm1_o;

   // External memory model
   data_t       mem [addr_t];
   int unsigned lcg_state = 12751;
   int          wait_left = -1;
   addr_t       last_addr;
   data_t       last_wdata;
   strb_t       last_wstrb;

   int valid_cycles = 0;
   int drsp_count = 0;
   int irsp_count = 0;
   int cycles = 0;
   int cycle_limit = 0;
   int error_count = 0;
   int pass_count = 0;
   int fail_count = 0;

   string case_op[$];
   string case_port[$];
   addr_t case_addr[$];
   data_t case_data[$];
   data_t case_exp[$];
   logic  case_err[$];

   system_bus i_system_bus (.*);

   initial clk = 1'b0;
   always #4 clk = ~clk;

   always @(posedge clk) begin
      cycles++;
      if (cycle_limit > 0 && cycles >= cycle_limit) begin
         $display("Timeout after %0d cycles, a case never completed", cycles);
         $display("SIMULATION FAILED");
         $finish;
      end
   end

   always @(negedge clk) begin
      if (iomem_valid_o) valid_cycles++;
      if (drsp_valid_o) drsp_count++;
      if (irsp_valid_o) irsp_count++;
   end

   function automatic int unsigned lcg_next();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state >> 16;
   endfunction

   // Unwritten words hold a pattern of their own address
   function automatic data_t model_word(input addr_t a);
      if (mem.exists(a)) return mem[a];
      return {a[15:0], a[31:16]} ^ 32'h5A5A_C3C3;
   endfunction

   function automatic logic is_mem(input addr_t a);
      return ((a & ~`RAM_MASK_ADDR) == `RAM_BASE_ADDR) ||
             ((a & ~`TIMER_MASK_ADDR) == `TIMER_BASE_ADDR);
   endfunction

   // Ready after 0 to 3 wait cycles and dropped again one cycle later
   always @(posedge clk) begin
      #1;
      if (iomem_ready_i) begin
         iomem_ready_i = 1'b0;
      end else if (resetn && iomem_valid_o) begin
         if (wait_left < 0) wait_left = lcg_next() % 4;
         if (wait_left == 0) begin
            last_addr  = iomem_addr_o;
            last_wdata = iomem_wdata_o;
            last_wstrb = iomem_wstrb_o;
            if (iomem_wstrb_o != '0) mem[iomem_addr_o] = iomem_wdata_o;
            iomem_rdata_i = model_word(iomem_addr_o);
            iomem_ready_i = 1'b1;
            wait_left = -1;
         end else begin
            wait_left--;
         end
      end
   end

   task automatic check_data(input string name, input data_t got, input data_t exp);
      if (got !== exp) begin
         $display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
         error_count++;
      end
   endtask

   task automatic check_rsp(input string name, input bus_rsp_t got, input bus_rsp_t exp);
      if (got !== exp) begin
         $display("[ERROR] %0t %s: got %h err %b, expected %h err %b", $time, name,
                  got.rdata, got.err, exp.rdata, exp.err);
         error_count++;
      end
   endtask

   task automatic check_count(input string name, input pwm_count_t got, input pwm_count_t exp);
      if (got !== exp) begin
         $display("[ERROR] %0t %s: got %0d, expected %0d", $time, name, got, exp);
         error_count++;
      end
   endtask

   task automatic single_access(input logic instr, input logic wr, input addr_t a,
                                input data_t d, output bus_rsp_t rsp);
      if (instr) begin
         ireq_addr_i  = a;
         ireq_valid_i = 1'b1;
      end else begin
         dreq_i       = '{addr: a, wdata: d, write: wr};
         dreq_valid_i = 1'b1;
      end
      @(negedge clk);
      while (!(instr ? ireq_ready_o : dreq_ready_o)) @(negedge clk);
      @(posedge clk);
      #1;
      ireq_valid_i = 1'b0;
      dreq_valid_i = 1'b0;
      @(negedge clk);
      while (!(instr ? irsp_valid_o : drsp_valid_o)) @(negedge clk);
      rsp = instr ? irsp_o : drsp_o;
   endtask

   // Both ports raise valid in the same cycle
   task automatic dual_access(input addr_t da, input addr_t ia,
                              output bus_rsp_t d_rsp, output bus_rsp_t i_rsp);
      int   d_acc;
      int   i_acc;
      logic d_done;
      logic i_done;
      d_acc  = -1;
      i_acc  = -1;
      d_done = 1'b0;
      i_done = 1'b0;
      dreq_i       = '{addr: da, wdata: '0, write: 1'b0};
      ireq_addr_i  = ia;
      dreq_valid_i = 1'b1;
      ireq_valid_i = 1'b1;
      while (!(d_done && i_done)) begin
         @(negedge clk);
         if (dreq_valid_i && dreq_ready_o) d_acc = cycles;
         if (ireq_valid_i && ireq_ready_o) i_acc = cycles;
         if (drsp_valid_o) begin
            d_rsp  = drsp_o;
            d_done = 1'b1;
         end
         if (irsp_valid_o) begin
            i_rsp  = irsp_o;
            i_done = 1'b1;
         end
         @(posedge clk);
         #1;
         if (d_acc >= 0) dreq_valid_i = 1'b0;
         if (i_acc >= 0) ireq_valid_i = 1'b0;
      end
      if (!(d_acc >= 0 && i_acc > d_acc)) begin
         $display("Data port was not accepted before the instruction port");
         error_count++;
      end
   endtask

   task automatic count_high(input logic sel, input int window, output pwm_count_t high);
      high = '0;
      repeat (window) begin
         @(negedge clk);
         if (sel ? pwm1_o : pwm0_o) high++;
      end
   endtask

   initial begin
      int                 fd;
      int                 code;
      int                 d0;
      int                 i0;
      int                 v0;
      int                 e0;
      int                 exp_d;
      int                 exp_i;
      string              op;
      string              port;
      logic [8*128-1:0]   line_buf;
      addr_t              a;
      data_t              d;
      data_t              e;
      logic [3:0]         err_in;
      logic               wr;
      logic               no_mem;
      bus_rsp_t           rsp;
      bus_rsp_t           irsp;
      bus_rsp_t           exp_rsp;
      pwm_count_t         high;

      resetn        = 1'b0;
      ireq_valid_i  = 1'b0;
      ireq_addr_i   = '0;
      dreq_valid_i  = 1'b0;
      dreq_i        = '0;
      iomem_ready_i = 1'b0;
      iomem_rdata_i = '0;

      fd = $fopen("testbench/system_bus_cases.txt", "r");
      if (fd == 0) begin
         $display("Cannot open testbench/system_bus_cases.txt");
         fail_count++;
      end else begin
         while (!$feof(fd)) begin
            code = $fscanf(fd, "%s", op);
            if (code != 1) break;
            if (op[0] == "#") begin
               code = $fgets(line_buf, fd);
            end else begin
               code = $fscanf(fd, "%s %h %h %h %h", port, a, d, e, err_in);
               case_op.push_back(op);
               case_port.push_back(port);
               case_addr.push_back(a);
               case_data.push_back(d);
               case_exp.push_back(e);
               case_err.push_back(err_in[0]);
            end
         end
         $fclose(fd);
      end
      cycle_limit = (case_op.size() + 1) * 200;

      repeat (2) @(posedge clk);
      #1;
      resetn = 1'b1;

      @(negedge clk);
      check_data("iomem_valid_o", data_t'(iomem_valid_o), '0);
      check_data("ireq_ready_o", data_t'(ireq_ready_o), '0);
      check_data("dreq_ready_o", data_t'(dreq_ready_o), '0);
      check_data("drsp_valid_o", data_t'(drsp_valid_o), '0);
      check_data("irsp_valid_o", data_t'(irsp_valid_o), '0);
      check_data("pwm0_o", data_t'(pwm0_o), '0);
      check_data("pwm1_o", data_t'(pwm1_o), '0);
      if (error_count == 0) pass_count++;
      else fail_count++;
      $display("reset state: %s", (error_count == 0) ? "pass" : "fail");
      @(posedge clk);
      #1;

      foreach (case_op[n]) begin
         e0 = error_count;
         d0 = drsp_count;
         i0 = irsp_count;
         v0 = valid_cycles;
         exp_d = 0;
         exp_i = 0;
         no_mem = 1'b0;
         if (case_op[n] == "pwm") begin
            count_high(case_port[n] == "p1", int'(case_data[n]), high);
            check_count((case_port[n] == "p1") ? "pwm1_o high cycles" : "pwm0_o high cycles",
                        high, pwm_count_t'(case_exp[n]));
         end else if (case_op[n] == "dual") begin
            dual_access(case_addr[n], case_data[n], rsp, irsp);
            exp_d = 1;
            exp_i = 1;
            exp_rsp = '{rdata: case_exp[n], err: case_err[n]};
            check_rsp("drsp_o", rsp, exp_rsp);
            exp_rsp = '{rdata: model_word(case_data[n]), err: 1'b0};
            check_rsp("irsp_o", irsp, exp_rsp);
         end else begin
            wr = (case_op[n] == "write");
            single_access(case_port[n] == "i", wr, case_addr[n], case_data[n], rsp);
            exp_i = (case_port[n] == "i") ? 1 : 0;
            exp_d = 1 - exp_i;
            exp_rsp = '{rdata: case_exp[n], err: case_err[n]};
            check_rsp((exp_i == 1) ? "irsp_o" : "drsp_o", rsp, exp_rsp);
            if (is_mem(case_addr[n])) begin
               check_data("iomem_addr_o", last_addr, case_addr[n]);
               check_data("iomem_wstrb_o", data_t'(last_wstrb),
                          wr ? data_t'({`BUS_STRB_BITS{1'b1}}) : data_t'(0));
               if (wr) check_data("iomem_wdata_o", last_wdata, case_data[n]);
            end else begin
               no_mem = 1'b1;
            end
         end
         repeat (2) @(posedge clk);
         #1;
         if (no_mem && valid_cycles != v0) begin
            $display("iomem_valid_o was raised for address %h", case_addr[n]);
            error_count++;
         end
         if (drsp_count - d0 != exp_d || irsp_count - i0 != exp_i) begin
            $display("Case %0d got %0d data and %0d fetch completions", n,
                     drsp_count - d0, irsp_count - i0);
            error_count++;
         end
         if (error_count == e0) pass_count++;
         else fail_count++;
         $display("case %0d %s %s %h: %s", n, case_op[n], case_port[n], case_addr[n],
                  (error_count == e0) ? "pass" : "fail");
      end

      $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
      if (fail_count == 0 && error_count == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule
